//--- ecc_pkg.sv
package ecc_pkg;

    localparam int max_cw_width     = 32;
    localparam int max_parity_width = 6;

    localparam int cw_len_8  = 8;
    localparam int cw_len_16 = 16;
    localparam int cw_len_32 = 32;

    localparam int parity_len_8  = 4;   // overall parity bit included
    localparam int parity_len_16 = 5;
    localparam int parity_len_32 = 6;

    localparam int info_len_8  = cw_len_8 - parity_len_8;
    localparam int info_len_16 = cw_len_16 - parity_len_16;
    localparam int info_len_32 = cw_len_32 - parity_len_32;

    // Row 0 is the lowest row. The top non-zero row is all ones and gives
    // the overall parity. Unused upper rows stay zero.
    localparam logic [max_parity_width-1:0][cw_len_8-1:0] h_matrix_8 =
        48'hFFE4_D2B1;

    localparam logic [max_parity_width-1:0][cw_len_16-1:0] h_matrix_16 =
        96'hFFFF_FE08_F1C4_CDA2_AB61;

    localparam logic [max_parity_width-1:0][cw_len_32-1:0] h_matrix_32 =
        192'hFFFF_FFFF_FFFE_0010_FF01_FC08_F0F1_E384_CCCD_9B42_AAAB_56C1;

    typedef enum logic [1:0] {
        mode_8    = 2'b00,
        mode_16   = 2'b01,
        mode_32   = 2'b10,
        mode_none = 2'b11
    } ecc_mode_t;

    typedef enum logic {
        op_encode = 1'b0,
        op_decode = 1'b1
    } ecc_op_t;

    typedef enum logic [1:0] {
        err_none   = 2'b00,     // syndrome is zero
        err_single = 2'b01,     // syndrome matched one column, bit corrected
        err_double = 2'b10,     // nonzero syndrome, no column match
        err_unused = 2'b11      // never produced
    } err_count_t;

    typedef struct packed {
        ecc_op_t                    op;
        ecc_mode_t                  mode;
        logic [max_cw_width-1:0]    data;
    } ecc_req_t;

    typedef struct packed {
        ecc_op_t                    op;
        logic [max_cw_width-1:0]    data;
        err_count_t                 err;
    } ecc_rsp_t;

    // parity-check matrix padded out to the full codeword width
    typedef logic [max_parity_width-1:0][max_cw_width-1:0] h_matrix_t;

    function automatic h_matrix_t h_matrix_sel(input ecc_mode_t mode);
        h_matrix_t h;
        h = '0;
        for (int r = 0; r < max_parity_width; r++) begin
            case (mode)
                mode_8: begin
                    h[r][cw_len_8-1:0] = h_matrix_8[r];
                end
                mode_16: begin
                    h[r][cw_len_16-1:0] = h_matrix_16[r];
                end
                mode_32: begin
                    h[r][cw_len_32-1:0] = h_matrix_32[r];
                end
                default: begin
                    h[r] = '0;          // mode_none has no checks at all
                end
            endcase
        end
        return h;
    endfunction

endpackage

//--- ecc_encoder.sv
module ecc_encoder (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start,
    input  ecc_pkg::ecc_mode_t                  mode,
    input  logic [ecc_pkg::max_cw_width-1:0]    info,
    output logic                                done,
    output logic [ecc_pkg::max_cw_width-1:0]    codeword
);
    import ecc_pkg::*;

    logic                       s1_valid;
    ecc_mode_t                  s1_mode;
    logic [max_cw_width-1:0]    s1_info;
    h_matrix_t                  h;
    logic [max_cw_width-1:0]    placed;     // info bits in their columns, parity slots zero
    logic [max_cw_width-1:0]    cw_next;
    int                         n_par;

    // stage one
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            s1_mode <= mode;
            s1_info <= info;
        end
    end

    // stage two: scatter info bits, then fill the parity columns
    always_comb begin
        h = h_matrix_sel(s1_mode);
        case (s1_mode)
            mode_8: begin
                n_par  = parity_len_8;
                placed = {{(max_cw_width-cw_len_8){1'b0}}, s1_info[info_len_8-1:0],
                          {parity_len_8{1'b0}}};
            end
            mode_16: begin
                n_par  = parity_len_16;
                placed = {{(max_cw_width-cw_len_16){1'b0}}, s1_info[info_len_16-1:0],
                          {parity_len_16{1'b0}}};
            end
            mode_32: begin
                n_par  = parity_len_32;
                placed = {s1_info[info_len_32-1:0], {parity_len_32{1'b0}}};
            end
            default: begin
                n_par  = 0;
                placed = s1_info;           // no code, data goes straight through
            end
        endcase

        cw_next = placed;
        for (int r = 0; r < max_parity_width; r++) begin
            if (r + 1 < n_par) begin
                cw_next[r] = ^(placed & h[r]);  // row r covers its own parity column once
            end
        end
        // overall parity last so that the whole word XORs to zero
        if (n_par > 0) begin
            cw_next[n_par-1] = ^cw_next;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            done     <= 1'b0;
            codeword <= '0;
        end else begin
            done <= s1_valid;
            if (s1_valid) begin
                codeword <= cw_next;
            end
        end
    end

endmodule

//--- ecc_syndrome.sv
module ecc_syndrome (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    start,
    input  ecc_pkg::ecc_mode_t                      mode,
    input  logic [ecc_pkg::max_cw_width-1:0]        word,
    output logic                                    syn_valid,
    output ecc_pkg::ecc_mode_t                      mode_q,
    output logic [ecc_pkg::max_cw_width-1:0]        word_q,
    output logic [ecc_pkg::max_parity_width-1:0]    syndrome
);
    import ecc_pkg::*;

    h_matrix_t                      h;
    logic [max_parity_width-1:0]    syn_next;

    // one parity check per matrix row; for mode_none every row is zero
    // and so is the syndrome
    always_comb begin
        h = h_matrix_sel(mode);
        for (int r = 0; r < max_parity_width; r++) begin
            syn_next[r] = ^(word & h[r]);
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            syn_valid <= 1'b0;
        end else begin
            syn_valid <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mode_q   <= mode;
            word_q   <= word;       // held for the correction stage
            syndrome <= syn_next;
        end
    end

endmodule

//--- ecc_correct.sv
module ecc_correct (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    syn_valid,
    input  ecc_pkg::ecc_mode_t                      mode,
    input  logic [ecc_pkg::max_cw_width-1:0]        word,
    input  logic [ecc_pkg::max_parity_width-1:0]    syndrome,
    output logic                                    done,
    output logic [ecc_pkg::max_cw_width-1:0]        word_out,
    output ecc_pkg::err_count_t                     err
);
    import ecc_pkg::*;

    h_matrix_t                                      h;
    logic [max_cw_width-1:0][max_parity_width-1:0]  h_t;        // one column per entry
    logic [max_cw_width-1:0]                        corr;       // bit to flip
    logic                                           eq_to_col;

    // Every real column has the overall-parity bit set, so a zero column
    // is padding above the mode length and must never match.
    always_comb begin
        h = h_matrix_sel(mode);
        for (int c = 0; c < max_cw_width; c++) begin
            for (int r = 0; r < max_parity_width; r++) begin
                h_t[c][r] = h[r][c];
            end
            corr[c] = (h_t[c] != '0) && (h_t[c] == syndrome);
        end
        eq_to_col = |corr;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            done     <= 1'b0;
            word_out <= '0;
            err      <= err_none;
        end else begin
            done <= syn_valid;
            if (syn_valid) begin
                word_out <= word ^ corr;    // no match leaves the word as received
                // order matters here, zero syndrome wins over everything
                if (syndrome == '0) begin
                    err <= err_none;
                end else if (eq_to_col) begin
                    err <= err_single;
                end else begin
                    err <= err_double;      // even number of flips
                end
            end
        end
    end

endmodule

//--- ecc_core.sv
module ecc_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    input  ecc_pkg::ecc_req_t   req,
    output logic                rsp_valid,
    output ecc_pkg::ecc_rsp_t   rsp
);
    import ecc_pkg::*;

    logic                           enc_start;
    logic                           dec_start;
    logic                           enc_done;
    logic [max_cw_width-1:0]        enc_codeword;
    logic                           syn_valid;
    ecc_mode_t                      syn_mode;
    logic [max_cw_width-1:0]        syn_word;
    logic [max_parity_width-1:0]    syn_vec;
    logic                           dec_done;
    logic [max_cw_width-1:0]        dec_word;
    err_count_t                     dec_err;

    // the opcode picks the path, the strobe tells the path apart later
    assign enc_start = req_valid && (req.op == op_encode);
    assign dec_start = req_valid && (req.op == op_decode);

    ecc_encoder u_encoder (
        .clk      (clk),
        .rst      (rst),
        .start    (enc_start),
        .mode     (req.mode),
        .info     (req.data),
        .done     (enc_done),
        .codeword (enc_codeword)
    );

    ecc_syndrome u_syndrome (
        .clk       (clk),
        .rst       (rst),
        .start     (dec_start),
        .mode      (req.mode),
        .word      (req.data),
        .syn_valid (syn_valid),
        .mode_q    (syn_mode),
        .word_q    (syn_word),
        .syndrome  (syn_vec)
    );

    ecc_correct u_correct (
        .clk       (clk),
        .rst       (rst),
        .syn_valid (syn_valid),
        .mode      (syn_mode),
        .word      (syn_word),
        .syndrome  (syn_vec),
        .done      (dec_done),
        .word_out  (dec_word),
        .err       (dec_err)
    );

    // both paths are two cycles deep, so at most one strobe per cycle
    assign rsp_valid = enc_done | dec_done;

    always_comb begin
        if (dec_done) begin
            rsp.op   = op_decode;
            rsp.data = dec_word;
            rsp.err  = dec_err;
        end else begin
            rsp.op   = op_encode;
            rsp.data = enc_codeword;
            rsp.err  = err_none;    // encode never reports errors
        end
    end

endmodule

//--- ecc_assertions.sv
module ecc_assertions (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    input  logic                rsp_valid,
    input  ecc_pkg::ecc_rsp_t   rsp
);
    timeunit 1ns;
    timeprecision 1ps;
    import ecc_pkg::*;

    // each request gives a result exactly two cycles later
    result_latency: assert property (@(posedge clk) disable iff (!rst)
        $past(req_valid, 2) |-> rsp_valid)
        else $error("no result two cycles after a request");

    // no result without a request two cycles earlier
    result_has_request: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid |-> $past(req_valid, 2))
        else $error("result strobe without a matching request");

    // the fourth error class is never reported
    err_in_range: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid |-> rsp.err != err_unused)
        else $error("result carries the unused error class");

endmodule

bind ecc_core ecc_assertions u_assertions (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
);

//--- tb_ecc_core.sv
module tb_ecc_core;
    timeunit 1ns;
    timeprecision 1ps;
    import ecc_pkg::*;

    typedef struct packed {
        ecc_mode_t                  mode;
        logic [max_cw_width-1:0]    info;
        logic [5:0]                 flip_a;     // 63 means no flip
        logic [5:0]                 flip_b;
    } vec_t;

    typedef struct packed {
        ecc_op_t                    op;
        ecc_mode_t                  mode;
        logic [max_cw_width-1:0]    data;
        err_count_t                 err;
    } exp_t;

    logic       clk;
    logic       rst;
    logic       req_valid;
    ecc_req_t   req;
    logic       rsp_valid;
    ecc_rsp_t   rsp;

    int         seed;
    int         cycle;
    int         checked;
    int         value_errors;
    int         timing_errors;
    int         timeouts;
    exp_t       exp_q[$];       // expected results in request order
    int         issue_q[$];     // cycle each request was seen
    vec_t       rows[$];

    vec_t fixed_rows [0:11] = '{
        '{mode_8,    32'h0000_0005, 6'd63, 6'd63},
        '{mode_8,    32'h0000_000A, 6'd2,  6'd63},
        '{mode_8,    32'h0000_000F, 6'd0,  6'd7},
        '{mode_8,    32'h0000_0000, 6'd5,  6'd6},
        '{mode_16,   32'h0000_05A5, 6'd63, 6'd63},
        '{mode_16,   32'h0000_07FF, 6'd15, 6'd63},
        '{mode_16,   32'h0000_0123, 6'd3,  6'd9},
        '{mode_32,   32'h03FF_FFFF, 6'd63, 6'd63},
        '{mode_32,   32'h02AA_AAAA, 6'd31, 6'd63},
        '{mode_32,   32'h0123_4567, 6'd0,  6'd30},
        '{mode_none, 32'hDEAD_BEEF, 6'd63, 6'd63},
        '{mode_none, 32'h1234_5678, 6'd4,  6'd63}
    };

    ecc_core dut0 (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    always #4 clk = ~clk;

    function automatic logic bit_at(input logic [max_cw_width-1:0] w, input int c);
        logic [max_cw_width-1:0] t;
        t = w >> c;
        return t[0];
    endfunction

    // one entry of the mode's parity-check matrix, zero outside it
    function automatic logic h_bit(input ecc_mode_t mode, input int r, input int c);
        logic [191:0] flat;
        int           len;
        flat = '0;
        len  = 0;
        case (mode)
            mode_8: begin
                flat[47:0] = h_matrix_8;
                len        = cw_len_8;
            end
            mode_16: begin
                flat[95:0] = h_matrix_16;
                len        = cw_len_16;
            end
            mode_32: begin
                flat = h_matrix_32;
                len  = cw_len_32;
            end
            default: begin
                len = 0;
            end
        endcase
        if (len == 0 || c >= len) begin
            return 1'b0;
        end
        flat = flat >> (r * len + c);
        return flat[0];
    endfunction

    function automatic int cw_length(input ecc_mode_t mode);
        case (mode)
            mode_8:  return cw_len_8;
            mode_16: return cw_len_16;
            default: return cw_len_32;
        endcase
    endfunction

    // number of used matrix rows, the top one being overall parity
    function automatic int parity_count(input ecc_mode_t mode);
        int   n;
        logic any;
        n = 0;
        for (int r = 0; r < max_parity_width; r++) begin
            any = 1'b0;
            for (int c = 0; c < max_cw_width; c++) begin
                any = any | h_bit(mode, r, c);
            end
            if (any) begin
                n = r + 1;
            end
        end
        return n;
    endfunction

    function automatic logic [max_cw_width-1:0] model_encode(input ecc_mode_t mode,
                                                            input logic [max_cw_width-1:0] info);
        logic [max_cw_width-1:0] cw;
        int                      len;
        int                      np;
        logic                    p;
        if (mode == mode_none) begin
            return info;
        end
        len = cw_length(mode);
        np  = parity_count(mode);
        cw  = '0;
        for (int c = np; c < len; c++) begin
            if (bit_at(info, c - np)) begin
                cw = cw | (32'd1 << c);     // info bits above the parity columns
            end
        end
        for (int r = 0; r < np - 1; r++) begin
            p = 1'b0;
            for (int c = np; c < len; c++) begin
                p = p ^ (bit_at(cw, c) & h_bit(mode, r, c));
            end
            if (p) begin
                cw = cw | (32'd1 << r);
            end
        end
        if (^cw) begin
            cw = cw | (32'd1 << (np - 1));  // overall parity evens out the word
        end
        return cw;
    endfunction

    function automatic logic [max_parity_width-1:0] syndrome_of(input ecc_mode_t mode,
                                                               input logic [max_cw_width-1:0] w);
        logic [max_parity_width-1:0] s;
        s = '0;
        for (int r = 0; r < max_parity_width; r++) begin
            for (int c = 0; c < max_cw_width; c++) begin
                if (h_bit(mode, r, c) && bit_at(w, c)) begin
                    s = s ^ (6'd1 << r);
                end
            end
        end
        return s;
    endfunction

    function automatic exp_t expect_decode(input ecc_mode_t mode,
                                           input logic [max_cw_width-1:0] cw,
                                           input logic [max_cw_width-1:0] rx, input int nflips);
        exp_t e;
        e.op   = op_decode;
        e.mode = mode;
        e.data = rx;
        e.err  = err_none;
        if (mode != mode_none) begin
            case (nflips)
                1: begin
                    e.data = cw;
                    e.err  = err_single;
                end
                2: e.err = err_double;     // received word comes back untouched
                default: e.data = cw;
            endcase
        end
        return e;
    endfunction

    function automatic logic [max_cw_width-1:0] rand_word();
        logic [max_cw_width-1:0] w;
        w = $random(seed);
        return w;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] w;
        w = $random(seed);
        return int'(w % 32'(n));
    endfunction

    function automatic ecc_mode_t mode_from_index(input int i);
        case (i)
            0:       return mode_8;
            1:       return mode_16;
            2:       return mode_32;
            default: return mode_none;
        endcase
    endfunction

    function automatic vec_t random_row(input ecc_mode_t mode, input int nflips);
        vec_t v;
        int   len;
        int   a;
        len      = cw_length(mode);
        v.mode   = mode;
        v.info   = rand_word();
        v.flip_a = 6'd63;
        v.flip_b = 6'd63;
        a        = rand_below(len);
        if (nflips > 0) begin
            v.flip_a = 6'(a);
        end
        if (nflips > 1) begin
            v.flip_b = 6'((a + 1 + rand_below(len - 1)) % len);   // never equal to flip_a
        end
        return v;
    endfunction

    task automatic build_table();
        foreach (fixed_rows[i]) begin
            rows.push_back(fixed_rows[i]);
        end
        for (int p = 0; p < cw_len_8; p++) begin
            rows.push_back(random_row(mode_8, 0));
            rows[rows.size()-1].flip_a = 6'(p);     // every single-bit position
        end
        repeat (4) begin
            rows.push_back(random_row(mode_16, 1));
            rows.push_back(random_row(mode_32, 1));
        end
        repeat (24) begin
            rows.push_back(random_row(mode_from_index(rand_below(4)), rand_below(3)));
        end
    endtask

    task automatic send(input ecc_op_t op, input ecc_mode_t mode,
                        input logic [max_cw_width-1:0] data, input exp_t e);
        @(posedge clk);
        req_valid <= 1'b1;
        req.op    <= op;
        req.mode  <= mode;
        req.data  <= data;
        exp_q.push_back(e);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            req_valid <= 1'b0;
        end
    endtask

    task automatic apply_row(input vec_t v);
        logic [max_cw_width-1:0] cw;
        logic [max_cw_width-1:0] rx;
        int                      nflips;
        exp_t                    e;
        cw     = model_encode(v.mode, v.info);
        rx     = cw;
        nflips = 0;
        if (v.flip_a != 6'd63) begin
            rx = rx ^ (32'd1 << v.flip_a);
            nflips++;
        end
        if (v.flip_b != 6'd63) begin
            rx = rx ^ (32'd1 << v.flip_b);
            nflips++;
        end
        e.op   = op_encode;
        e.mode = v.mode;
        e.data = cw;
        e.err  = err_none;
        send(op_encode, v.mode, v.info, e);
        send(op_decode, v.mode, rx, expect_decode(v.mode, cw, rx, nflips));
    endtask

    task automatic check_response(input exp_t e, input int latency);
        checked++;
        if (latency != 2) begin
            timing_errors++;
            $display("[ERROR] %0t: result after %0d cycles, expected 2", $time, latency);
        end
        if (rsp.op != e.op) begin
            value_errors++;
            $display("[ERROR] %0t: op %0d, expected %0d", $time, rsp.op, e.op);
        end
        if (rsp.data != e.data) begin
            value_errors++;
            $display("[ERROR] %0t: data %h, expected %h (op %0d mode %0d)",
                     $time, rsp.data, e.data, e.op, e.mode);
        end
        if (rsp.err != e.err) begin
            value_errors++;
            $display("[ERROR] %0t: err %0d, expected %0d (mode %0d)",
                     $time, rsp.err, e.err, e.mode);
        end
        if (e.op == op_encode && e.mode != mode_none) begin
            if (syndrome_of(e.mode, rsp.data) != '0) begin
                value_errors++;
                $display("[ERROR] %0t: codeword %h has a nonzero syndrome", $time, rsp.data);
            end
            if ((rsp.data >> cw_length(e.mode)) != '0) begin
                value_errors++;
                $display("[ERROR] %0t: codeword %h has bits above its length", $time, rsp.data);
            end
        end
    endtask

    // sample away from the rising edge, where everything is settled
    always @(negedge clk) begin
        exp_t e;
        int   issued;
        if (rsp_valid) begin
            if (exp_q.size() == 0 || issue_q.size() == 0) begin
                timing_errors++;
                $display("%0t: a result came out with no request outstanding", $time);
            end else begin
                e      = exp_q.pop_front();
                issued = issue_q.pop_front();
                check_response(e, cycle - issued);
            end
        end
        if (req_valid) begin
            issue_q.push_back(cycle);
        end
        cycle++;
    end

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            timeouts++;
            $display("timed out waiting for %0d outstanding results", exp_q.size());
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b0;
        req_valid     = 1'b0;
        req           = '0;
        seed          = 32'ha4b6;
        cycle         = 0;
        checked       = 0;
        value_errors  = 0;
        timing_errors = 0;
        timeouts      = 0;
        build_table();
        repeat (16) @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        foreach (rows[i]) begin
            apply_row(rows[i]);         // mostly back to back
            if (rand_below(4) == 0) begin
                idle(1);
            end
        end
        idle(1);
        wait_for_drain();
        idle(4);                        // catch any stray result
        $display("results checked: %0d, value errors: %0d, timing errors: %0d, timeouts: %0d",
                 checked, value_errors, timing_errors, timeouts);
        if (value_errors + timing_errors + timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- verilog.f
ecc_pkg.sv
ecc_encoder.sv
ecc_syndrome.sv
ecc_correct.sv
ecc_core.sv
ecc_assertions.sv
tb_ecc_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ecc_core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module tb_ecc_core \
    -Mdir obj_dir > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_ecc_core +verilator+error+limit+100 > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$SIM_LOG"; then
    echo "FAIL"
    exit 1
fi

echo "PASS"
exit 0
